//--- src/vlsu_geom_pkg.sv
/*
  Beat geometry shared by the store deshuffle path. DLEN is fixed at 64 bits.
  MAX_ELEMS covers four exits at 8-bit elements; wider builds need a larger value.
*/
`default_nettype none

package vlsu_geom_pkg;

  // Lane chunk geometry
  localparam int unsigned DLEN        = 64;
  localparam int unsigned NB_PER_LANE = DLEN / 4;
  localparam int unsigned MAX_ELEMS   = 32;

  typedef logic [3:0]             nibble_t;
  typedef logic [DLEN-1:0]        lane_data_t;
  typedef logic [NB_PER_LANE-1:0] lane_strb_t;

  // --------------------------------------------------
  // Sequential nibble index to shuffled nibble index
  // --------------------------------------------------
  // sew is log2 of the element size in bytes
  function automatic int unsigned shf_idx(input int unsigned nr_exits,
                                          input int unsigned seq_idx,
                                          input logic [1:0]  sew);
    int unsigned e;
    int unsigned elem;
    int unsigned k;
    int unsigned lane;
    int unsigned off;
    // Nibbles per element: 2, 4, 8 or 16
    e    = 2 << sew;
    elem = seq_idx / e;
    k    = seq_idx % e;
    // Elements dealt round robin over the exits
    lane = elem % nr_exits;
    off  = (elem / nr_exits) * e + k;
    return lane * NB_PER_LANE + off;
  endfunction

endpackage

`default_nettype wire

//--- src/vlsu_req_pkg.sv
/*
  Request metadata types. Commit counts hold beats minus one,
  so one request spans at most 16 beats.
*/
`default_nettype none

package vlsu_req_pkg;

  // Element width, encoded as log2 of bytes
  typedef enum logic [1:0] {
    SEW8  = 2'd0,
    SEW16 = 2'd1,
    SEW32 = 2'd2,
    SEW64 = 2'd3
  } sew_e;

  typedef logic [3:0] req_id_t;

  // Remaining beats minus one
  typedef logic [3:0] cmt_cnt_t;

  // Beat position within a request
  typedef logic [3:0] beat_idx_t;

endpackage

`default_nettype wire

//--- src/mask_unit.sv
/*
  Holds one mask beat and scatters it into lane order.
  Element bits beyond MAX_ELEMS read as disabled.
*/
`timescale 1ns/1ps
`default_nettype none

module mask_unit #(
  parameter int unsigned NR_EXITS = 4
) (
  input  wire logic                                     clk_i,
  input  wire logic                                     rst_ni,
  input  wire logic                                     msk_valid_i,
  input  wire vlsu_req_pkg::sew_e                       msk_sew_i,
  input  wire logic [vlsu_geom_pkg::MAX_ELEMS-1:0]      msk_elem_i,
  output logic                                          msk_ready_o,
  output logic [NR_EXITS-1:0]                           lane_msk_valid_o,
  output vlsu_geom_pkg::lane_strb_t [NR_EXITS-1:0]      lane_msk_bits_o,
  input  wire logic                                     msk_take_i
);

  localparam int unsigned NB    = vlsu_geom_pkg::NB_PER_LANE;
  localparam int unsigned NR_NB = NR_EXITS * NB;

  // Held mask beat
  logic                                  msk_valid_q;
  vlsu_req_pkg::sew_e                    msk_sew_q;
  logic [vlsu_geom_pkg::MAX_ELEMS-1:0]   msk_elem_q;

  // Lane masks for each element width
  vlsu_geom_pkg::lane_strb_t [3:0][NR_EXITS-1:0] cand;

  assign msk_ready_o      = !msk_valid_q;
  assign lane_msk_valid_o = {NR_EXITS{msk_valid_q}};

  // --------------------------------------------------
  // Expand and scatter
  // --------------------------------------------------
  always_comb begin
    int unsigned idx;
    int unsigned elem;
    cand = '0;
    for (int s = 0; s < 4; s++) begin
      for (int n = 0; n < NR_NB; n++) begin
        // Every nibble of an element copies its bit
        elem = n / (2 << s);
        idx  = vlsu_geom_pkg::shf_idx(NR_EXITS, n, s[1:0]);
        if (elem < vlsu_geom_pkg::MAX_ELEMS) begin
          cand[s][idx / NB][idx % NB] = msk_elem_q[elem];
        end
      end
    end
  end

  assign lane_msk_bits_o = cand[msk_sew_q];

  // Valid level until taken
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      msk_valid_q <= 1'b0;
    end else if (msk_valid_i && msk_ready_o) begin
      msk_valid_q <= 1'b1;
    end else if (msk_take_i) begin
      msk_valid_q <= 1'b0;
    end
  end

  // Mask payload
  always_ff @(posedge clk_i) begin
    if (msk_valid_i && msk_ready_o) begin
      msk_sew_q  <= msk_sew_i;
      msk_elem_q <= msk_elem_i;
    end
  end

endmodule

`default_nettype wire

//--- src/mdeshuffle_unit.sv
/*
  Gathers one chunk per lane exit and emits a deshuffled, masked beat.
  SHF_INFO_DEPTH must be 2 or more. All exits must agree on the beat order.
*/
`timescale 1ns/1ps
`default_nettype none

module mdeshuffle_unit #(
  parameter int unsigned NR_EXITS       = 4,
  parameter int unsigned SHF_INFO_DEPTH = 4
) (
  input  wire logic                                             clk_i,
  input  wire logic                                             rst_ni,
  input  wire logic [NR_EXITS-1:0]                              lane_valid_i,
  input  wire vlsu_geom_pkg::lane_data_t [NR_EXITS-1:0]         lane_data_i,
  output logic [NR_EXITS-1:0]                                   lane_ready_o,
  input  wire logic                                             meta_valid_i,
  input  wire vlsu_req_pkg::req_id_t                            meta_req_id_i,
  input  wire vlsu_req_pkg::sew_e                               meta_sew_i,
  input  wire logic                                             meta_vm_i,
  input  wire vlsu_req_pkg::cmt_cnt_t                           meta_cmt_cnt_i,
  output logic                                                  meta_ready_o,
  input  wire logic [NR_EXITS-1:0]                              lane_msk_valid_i,
  input  wire vlsu_geom_pkg::lane_strb_t [NR_EXITS-1:0]         lane_msk_bits_i,
  output logic                                                  msk_take_o,
  output logic                                                  seq_valid_o,
  output logic [NR_EXITS*vlsu_geom_pkg::DLEN-1:0]               seq_data_o,
  output logic [NR_EXITS*vlsu_geom_pkg::NB_PER_LANE-1:0]        seq_en_o,
  output vlsu_req_pkg::req_id_t                                 seq_req_id_o,
  output logic                                                  seq_last_o,
  input  wire logic                                             seq_ready_i
);

  localparam int unsigned NB    = vlsu_geom_pkg::NB_PER_LANE;
  localparam int unsigned NR_NB = NR_EXITS * NB;
  localparam int unsigned PTR_W = $clog2(SHF_INFO_DEPTH);

  // Lane chunk slots
  logic [NR_EXITS-1:0]                      slot_valid;
  vlsu_geom_pkg::lane_data_t [NR_EXITS-1:0] slot_data;

  // Metadata queue, one field per array
  vlsu_req_pkg::req_id_t  q_req_id [SHF_INFO_DEPTH];
  vlsu_req_pkg::sew_e     q_sew    [SHF_INFO_DEPTH];
  logic                   q_vm     [SHF_INFO_DEPTH];
  vlsu_req_pkg::cmt_cnt_t q_cnt    [SHF_INFO_DEPTH];

  // Pointer MSB is the wrap flag
  logic [PTR_W:0] enq_ptr;
  logic [PTR_W:0] deq_ptr;
  logic           q_empty;
  logic           q_full;
  logic           q_enq;
  logic           q_deq;

  // Head entry
  vlsu_req_pkg::sew_e     head_sew;
  logic                   head_vm;
  vlsu_req_pkg::cmt_cnt_t head_cnt;

  logic commit;

  // Deshuffle candidates for each element width
  vlsu_geom_pkg::nibble_t [3:0][NR_NB-1:0] cand_data;
  logic [3:0][NR_NB-1:0]                   cand_en;

  // Advance one pointer, toggling the flag on wrap
  function automatic logic [PTR_W:0] ptr_step(input logic [PTR_W:0] p);
    if (p[PTR_W-1:0] == PTR_W'(SHF_INFO_DEPTH - 1)) begin
      return {~p[PTR_W], {PTR_W{1'b0}}};
    end
    return p + 1'b1;
  endfunction

  // --------------------------------------------------
  // Queue status and head
  // --------------------------------------------------
  assign q_empty = (enq_ptr == deq_ptr);
  assign q_full  = (enq_ptr[PTR_W-1:0] == deq_ptr[PTR_W-1:0]) &&
                   (enq_ptr[PTR_W] != deq_ptr[PTR_W]);

  assign head_sew = q_sew[deq_ptr[PTR_W-1:0]];
  assign head_vm  = q_vm[deq_ptr[PTR_W-1:0]];
  assign head_cnt = q_cnt[deq_ptr[PTR_W-1:0]];

  assign meta_ready_o = !q_full;
  assign q_enq        = meta_valid_i && meta_ready_o;

  // Slot accepts while empty
  assign lane_ready_o = ~slot_valid;

  // --------------------------------------------------
  // Commit condition
  // --------------------------------------------------
  // Unmasked requests ignore the mask path
  assign seq_valid_o = (&slot_valid) && !q_empty && (head_vm || (&lane_msk_valid_i));
  assign commit      = seq_valid_o && seq_ready_i;
  assign q_deq       = commit && (head_cnt == '0);
  assign msk_take_o  = commit && !head_vm;

  assign seq_req_id_o = q_req_id[deq_ptr[PTR_W-1:0]];
  assign seq_last_o   = (head_cnt == '0);

  // Width is a constant inside the loop so every index unrolls
  always_comb begin
    int unsigned idx;
    for (int s = 0; s < 4; s++) begin
      for (int n = 0; n < NR_NB; n++) begin
        idx             = vlsu_geom_pkg::shf_idx(NR_EXITS, n, s[1:0]);
        cand_data[s][n] = slot_data[idx / NB][(idx % NB)*4 +: 4];
        cand_en[s][n]   = lane_msk_bits_i[idx / NB][idx % NB];
      end
    end
  end

  // Head width picks the candidate
  assign seq_data_o = cand_data[head_sew];
  assign seq_en_o   = head_vm ? '1 : cand_en[head_sew];

  // --------------------------------------------------
  // Slots
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      slot_valid <= '0;
    end else if (commit) begin
      slot_valid <= '0;
    end else begin
      slot_valid <= slot_valid | (lane_valid_i & lane_ready_o);
    end
  end

  // Chunk payload
  always_ff @(posedge clk_i) begin
    for (int l = 0; l < NR_EXITS; l++) begin
      if (lane_valid_i[l] && lane_ready_o[l]) begin
        slot_data[l] <= lane_data_i[l];
      end
    end
  end

  // --------------------------------------------------
  // Queue pointers and entries
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      enq_ptr <= '0;
      deq_ptr <= '0;
    end else begin
      if (q_enq) begin
        enq_ptr <= ptr_step(enq_ptr);
      end
      if (q_deq) begin
        deq_ptr <= ptr_step(deq_ptr);
      end
    end
  end

  // Enqueue and head never share an entry unless the queue is empty
  always_ff @(posedge clk_i) begin
    if (q_enq) begin
      q_req_id[enq_ptr[PTR_W-1:0]] <= meta_req_id_i;
      q_sew[enq_ptr[PTR_W-1:0]]    <= meta_sew_i;
      q_vm[enq_ptr[PTR_W-1:0]]     <= meta_vm_i;
      q_cnt[enq_ptr[PTR_W-1:0]]    <= meta_cmt_cnt_i;
    end
    // Head stays for another beat
    if (commit && !q_deq) begin
      q_cnt[deq_ptr[PTR_W-1:0]] <= head_cnt - 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- src/seq_store_unit.sv
/*
  Single output register between the deshuffle unit and memory.
  A byte is written only when both of its nibbles are enabled.
*/
`timescale 1ns/1ps
`default_nettype none

module seq_store_unit #(
  parameter int unsigned NR_EXITS = 4
) (
  input  wire logic                                          clk_i,
  input  wire logic                                          rst_ni,
  input  wire logic                                          seq_valid_i,
  input  wire logic [NR_EXITS*vlsu_geom_pkg::DLEN-1:0]       seq_data_i,
  input  wire logic [NR_EXITS*vlsu_geom_pkg::NB_PER_LANE-1:0] seq_en_i,
  input  wire vlsu_req_pkg::req_id_t                         seq_req_id_i,
  input  wire logic                                          seq_last_i,
  output logic                                               seq_ready_o,
  output logic                                               mem_valid_o,
  output logic [NR_EXITS*vlsu_geom_pkg::DLEN-1:0]            mem_data_o,
  output logic [NR_EXITS*vlsu_geom_pkg::DLEN/8-1:0]          mem_strb_o,
  output vlsu_req_pkg::req_id_t                              mem_req_id_o,
  output vlsu_req_pkg::beat_idx_t                            mem_beat_o,
  output logic                                               mem_last_o,
  input  wire logic                                          mem_ready_i
);

  localparam int unsigned NR_BYTES = NR_EXITS * vlsu_geom_pkg::DLEN / 8;

  logic                    load;
  logic [NR_BYTES-1:0]     byte_en;
  vlsu_req_pkg::beat_idx_t beat_cnt;

  // Free slot or slot draining this cycle
  assign seq_ready_o = !mem_valid_o || mem_ready_i;
  assign load        = seq_valid_i && seq_ready_o;

  // Nibble pair to byte strobe
  always_comb begin
    for (int b = 0; b < NR_BYTES; b++) begin
      byte_en[b] = seq_en_i[2*b] & seq_en_i[2*b+1];
    end
  end

  // --------------------------------------------------
  // Control state
  // --------------------------------------------------
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      mem_valid_o <= 1'b0;
      beat_cnt    <= '0;
    end else if (load) begin
      mem_valid_o <= 1'b1;
      // Count restarts after the last beat
      beat_cnt    <= seq_last_i ? '0 : beat_cnt + 1'b1;
    end else if (mem_ready_i) begin
      mem_valid_o <= 1'b0;
    end
  end

  // Beat payload, held under back-pressure
  always_ff @(posedge clk_i) begin
    if (load) begin
      mem_data_o   <= seq_data_i;
      mem_strb_o   <= byte_en;
      mem_req_id_o <= seq_req_id_i;
      mem_beat_o   <= beat_cnt;
      mem_last_o   <= seq_last_i;
    end
  end

endmodule

`default_nettype wire

//--- src/vlsu_store_top.sv
/*
  Store deshuffle path: mask unit and lane exits feed the deshuffle unit,
  whose beats leave through the store unit's output register.
*/
`timescale 1ns/1ps
`default_nettype none

module vlsu_store_top #(
  parameter int unsigned NR_EXITS       = 4,
  parameter int unsigned SHF_INFO_DEPTH = 4
) (
  input  wire logic                                     clk_i,
  input  wire logic                                     rst_ni,
  // Lane exits
  input  wire logic [NR_EXITS-1:0]                      lane_valid_i,
  input  wire vlsu_geom_pkg::lane_data_t [NR_EXITS-1:0] lane_data_i,
  output logic [NR_EXITS-1:0]                           lane_ready_o,
  // Request metadata
  input  wire logic                                     meta_valid_i,
  input  wire vlsu_req_pkg::req_id_t                    meta_req_id_i,
  input  wire vlsu_req_pkg::sew_e                       meta_sew_i,
  input  wire logic                                     meta_vm_i,
  input  wire vlsu_req_pkg::cmt_cnt_t                   meta_cmt_cnt_i,
  output logic                                          meta_ready_o,
  // Mask source
  input  wire logic                                     msk_valid_i,
  input  wire vlsu_req_pkg::sew_e                       msk_sew_i,
  input  wire logic [vlsu_geom_pkg::MAX_ELEMS-1:0]      msk_elem_i,
  output logic                                          msk_ready_o,
  // Memory write port
  output logic                                          mem_valid_o,
  output logic [NR_EXITS*vlsu_geom_pkg::DLEN-1:0]       mem_data_o,
  output logic [NR_EXITS*vlsu_geom_pkg::DLEN/8-1:0]     mem_strb_o,
  output vlsu_req_pkg::req_id_t                         mem_req_id_o,
  output vlsu_req_pkg::beat_idx_t                       mem_beat_o,
  output logic                                          mem_last_o,
  input  wire logic                                     mem_ready_i
);

  // Mask unit to deshuffle unit
  logic [NR_EXITS-1:0]                      lane_msk_valid;
  vlsu_geom_pkg::lane_strb_t [NR_EXITS-1:0] lane_msk_bits;
  logic                                     msk_take;

  // Deshuffle unit to store unit
  logic                                               seq_valid;
  logic [NR_EXITS*vlsu_geom_pkg::DLEN-1:0]            seq_data;
  logic [NR_EXITS*vlsu_geom_pkg::NB_PER_LANE-1:0]     seq_en;
  vlsu_req_pkg::req_id_t                              seq_req_id;
  logic                                               seq_last;
  logic                                               seq_ready;

  mask_unit #(
    .NR_EXITS(NR_EXITS)
  ) u_mask (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .msk_valid_i      (msk_valid_i),
    .msk_sew_i        (msk_sew_i),
    .msk_elem_i       (msk_elem_i),
    .msk_ready_o      (msk_ready_o),
    .lane_msk_valid_o (lane_msk_valid),
    .lane_msk_bits_o  (lane_msk_bits),
    .msk_take_i       (msk_take)
  );

  mdeshuffle_unit #(
    .NR_EXITS       (NR_EXITS),
    .SHF_INFO_DEPTH (SHF_INFO_DEPTH)
  ) u_deshuffle (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .lane_valid_i     (lane_valid_i),
    .lane_data_i      (lane_data_i),
    .lane_ready_o     (lane_ready_o),
    .meta_valid_i     (meta_valid_i),
    .meta_req_id_i    (meta_req_id_i),
    .meta_sew_i       (meta_sew_i),
    .meta_vm_i        (meta_vm_i),
    .meta_cmt_cnt_i   (meta_cmt_cnt_i),
    .meta_ready_o     (meta_ready_o),
    .lane_msk_valid_i (lane_msk_valid),
    .lane_msk_bits_i  (lane_msk_bits),
    .msk_take_o       (msk_take),
    .seq_valid_o      (seq_valid),
    .seq_data_o       (seq_data),
    .seq_en_o         (seq_en),
    .seq_req_id_o     (seq_req_id),
    .seq_last_o       (seq_last),
    .seq_ready_i      (seq_ready)
  );

  seq_store_unit #(
    .NR_EXITS(NR_EXITS)
  ) u_store (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .seq_valid_i  (seq_valid),
    .seq_data_i   (seq_data),
    .seq_en_i     (seq_en),
    .seq_req_id_i (seq_req_id),
    .seq_last_i   (seq_last),
    .seq_ready_o  (seq_ready),
    .mem_valid_o  (mem_valid_o),
    .mem_data_o   (mem_data_o),
    .mem_strb_o   (mem_strb_o),
    .mem_req_id_o (mem_req_id_o),
    .mem_beat_o   (mem_beat_o),
    .mem_last_o   (mem_last_o),
    .mem_ready_i  (mem_ready_i)
  );

endmodule

`default_nettype wire

//--- sim/tb_clk_gen.sv
/*
  Free-running 4 ns clock. Reset is held low for RST_CYCLES rising edges
  and released on a falling edge.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
  parameter int unsigned RST_CYCLES = 16
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #2 clk_o = ~clk_o;
  end

  // Release away from the rising edge
  initial begin
    rst_no = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_no <= 1'b1;
  end

endmodule

`default_nettype wire

//--- sim/tb_vlsu_store.sv
/*
  Random store traffic from a fixed LFSR seed, checked against a nibble model.
  Assumes four exits, MAX_ELEMS of 32 and at most 16 beats per request.
*/
`timescale 1ns/1ps
`default_nettype none

module tb_vlsu_store;

  localparam int unsigned NR_EXITS       = 4;
  localparam int unsigned SHF_INFO_DEPTH = 4;
  localparam int unsigned DLEN           = vlsu_geom_pkg::DLEN;
  localparam int unsigned DW             = NR_EXITS * DLEN;
  localparam int unsigned SW             = DW / 8;
  localparam int unsigned NN             = DW / 4;

  logic clk;
  logic rst_n;

  // DUT inputs
  logic [NR_EXITS-1:0]                 lane_valid;
  logic [DW-1:0]                       lane_data;
  logic                                meta_valid;
  vlsu_req_pkg::req_id_t               meta_req_id;
  vlsu_req_pkg::sew_e                  meta_sew;
  logic                                meta_vm;
  vlsu_req_pkg::cmt_cnt_t              meta_cnt;
  logic                                msk_valid;
  vlsu_req_pkg::sew_e                  msk_sew;
  logic [vlsu_geom_pkg::MAX_ELEMS-1:0] msk_elem;
  logic                                mem_ready;

  // DUT outputs
  logic [NR_EXITS-1:0]     lane_ready;
  logic                    meta_ready;
  logic                    msk_ready;
  logic                    mem_valid;
  logic [DW-1:0]           mem_data;
  logic [SW-1:0]           mem_strb;
  vlsu_req_pkg::req_id_t   mem_req_id;
  vlsu_req_pkg::beat_idx_t mem_beat;
  logic                    mem_last;

  // Stimulus state
  logic [31:0]   lfsr_state;
  logic [3:0]    next_id;
  // Meta entries hold {id, sew, vm, cnt}
  logic [10:0]   meta_q [$];
  // Mask entries hold {sew, elems}
  logic [33:0]   msk_q [$];
  logic [DW-1:0] beat_q [$];
  int            lane_ptr [NR_EXITS];

  // Expected memory beats with tags {id, beat, last}
  logic [DW-1:0] exp_data_q [$];
  logic [SW-1:0] exp_strb_q [$];
  logic [8:0]    exp_tag_q [$];

  logic        want_meta_free;
  int unsigned chk_cnt;
  int unsigned err_cnt;
  int unsigned tmo_cnt;

  tb_clk_gen #(
    .RST_CYCLES(16)
  ) u_clk (
    .clk_o  (clk),
    .rst_no (rst_n)
  );

  vlsu_store_top #(
    .NR_EXITS       (NR_EXITS),
    .SHF_INFO_DEPTH (SHF_INFO_DEPTH)
  ) dut (
    .clk_i          (clk),
    .rst_ni         (rst_n),
    .lane_valid_i   (lane_valid),
    .lane_data_i    (lane_data),
    .lane_ready_o   (lane_ready),
    .meta_valid_i   (meta_valid),
    .meta_req_id_i  (meta_req_id),
    .meta_sew_i     (meta_sew),
    .meta_vm_i      (meta_vm),
    .meta_cmt_cnt_i (meta_cnt),
    .meta_ready_o   (meta_ready),
    .msk_valid_i    (msk_valid),
    .msk_sew_i      (msk_sew),
    .msk_elem_i     (msk_elem),
    .msk_ready_o    (msk_ready),
    .mem_valid_o    (mem_valid),
    .mem_data_o     (mem_data),
    .mem_strb_o     (mem_strb),
    .mem_req_id_o   (mem_req_id),
    .mem_beat_o     (mem_beat),
    .mem_last_o     (mem_last),
    .mem_ready_i    (mem_ready)
  );

  // --------------------------------------------------
  // Random source and reference model
  // --------------------------------------------------
  // Fibonacci LFSR with taps 32 22 2 1
  // One step per bit taken
  function automatic logic [31:0] rand_bits(input int unsigned n);
    logic [31:0] r;
    logic        fb;
    r = '0;
    for (int unsigned i = 0; i < n; i++) begin
      fb         = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
      lfsr_state = {lfsr_state[30:0], fb};
      r          = {r[30:0], fb};
    end
    return r;
  endfunction

  // Sequential nibble to its lane-order position
  function automatic int unsigned lane_pos(input int unsigned n, input logic [1:0] sew);
    int unsigned e;
    int unsigned elem;
    e    = 2 << sew;
    elem = n / e;
    return (elem % NR_EXITS) * vlsu_geom_pkg::NB_PER_LANE + (elem / NR_EXITS) * e + n % e;
  endfunction

  function automatic logic [DW-1:0] deshuffle_beat(input logic [DW-1:0] chunks,
                                                   input logic [1:0]    sew);
    logic [DW-1:0] out;
    for (int unsigned n = 0; n < NN; n++) begin
      out[n*4 +: 4] = chunks[lane_pos(n, sew)*4 +: 4];
    end
    return out;
  endfunction

  // Both nibbles of a byte sit in one element
  function automatic logic [SW-1:0] mask_strobes(input logic [31:0] msk,
                                                 input logic [1:0]  sew);
    logic [SW-1:0] strb;
    int unsigned   elem;
    for (int unsigned b = 0; b < SW; b++) begin
      elem    = (2 * b) / (2 << sew);
      strb[b] = (elem < vlsu_geom_pkg::MAX_ELEMS) ? msk[elem] : 1'b0;
    end
    return strb;
  endfunction

  // Negative selectors draw from the LFSR
  task automatic add_request(input int sew_sel, input int vm_sel);
    logic [31:0]   r;
    logic [1:0]    sew;
    logic          vm;
    logic [3:0]    cnt;
    logic [DW-1:0] chunks;
    r   = rand_bits(2);
    sew = (sew_sel < 0) ? r[1:0] : sew_sel[1:0];
    r   = rand_bits(1);
    vm  = (vm_sel < 0) ? r[0] : vm_sel[0];
    r   = rand_bits(4);
    cnt = r[3:0];
    meta_q.push_back({next_id, sew, vm, cnt});
    for (int b = 0; b <= int'(cnt); b++) begin
      for (int l = 0; l < NR_EXITS; l++) begin
        r                            = rand_bits(32);
        chunks[l*DLEN +: 32]         = r;
        r                            = rand_bits(32);
        chunks[l*DLEN + 32 +: 32]    = r;
      end
      beat_q.push_back(chunks);
      exp_data_q.push_back(deshuffle_beat(chunks, sew));
      r = rand_bits(32);
      if (vm) begin
        exp_strb_q.push_back('1);
      end else begin
        msk_q.push_back({sew, r});
        exp_strb_q.push_back(mask_strobes(r, sew));
      end
      exp_tag_q.push_back({next_id, 4'(b), b == int'(cnt)});
    end
    next_id = next_id + 4'd1;
  endtask

  // --------------------------------------------------
  // Scoreboard
  // --------------------------------------------------
  // Called on a falling edge where the write will be taken
  task automatic check_beat();
    logic [DW-1:0] e_data;
    logic [SW-1:0] e_strb;
    logic [8:0]    e_tag;
    if (exp_data_q.size() == 0) begin
      $display("Memory write at %0t with no beat outstanding", $time);
      err_cnt++;
      return;
    end
    e_data = exp_data_q.pop_front();
    e_strb = exp_strb_q.pop_front();
    e_tag  = exp_tag_q.pop_front();
    chk_cnt++;
    assert (mem_data == e_data) else begin
      $display("FAILED %0t: mem_data_o %h expected %h", $time, mem_data, e_data);
      err_cnt++;
    end
    assert (mem_strb == e_strb) else begin
      $display("FAILED %0t: mem_strb_o %h expected %h", $time, mem_strb, e_strb);
      err_cnt++;
    end
    assert ({mem_req_id, mem_beat} == e_tag[8:1]) else begin
      $display("FAILED %0t: id/beat %h/%0d expected %h/%0d", $time,
               mem_req_id, mem_beat, e_tag[8:5], e_tag[4:1]);
      err_cnt++;
    end
    assert (mem_last == e_tag[0]) else begin
      $display("FAILED %0t: mem_last_o %b expected %b", $time, mem_last, e_tag[0]);
      err_cnt++;
    end
    // First finished request frees one queue entry
    if (e_tag[0] && want_meta_free) begin
      want_meta_free = 1'b0;
      assert (meta_ready) else begin
        $display("FAILED %0t: meta_ready_o still low after a request completed", $time);
        err_cnt++;
      end
    end
  endtask

  function automatic logic traffic_pending();
    logic busy;
    busy = (meta_q.size() != 0) || (msk_q.size() != 0) || (exp_data_q.size() != 0);
    for (int l = 0; l < NR_EXITS; l++) begin
      busy = busy || (lane_ptr[l] < beat_q.size());
    end
    return busy;
  endfunction

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------
  // Ready outputs come from registers so a transfer is known at the falling edge
  task automatic run_traffic(input logic gaps, input int unsigned limit);
    int unsigned   cyc;
    logic [31:0]   r;
    logic [1:0]    sew;
    logic [DW-1:0] chunks;
    cyc = 0;
    while (traffic_pending()) begin
      if (cyc >= limit) begin
        $display("Timeout: %0d memory beats never arrived", exp_data_q.size());
        tmo_cnt++;
        break;
      end
      @(negedge clk);
      cyc++;
      r         = rand_bits(2);
      mem_ready = !gaps || (r[1:0] != 2'b00);
      if (mem_ready && mem_valid) begin
        check_beat();
      end
      r          = rand_bits(1);
      meta_valid = (meta_q.size() != 0) && (!gaps || r[0]);
      if (meta_valid) begin
        {meta_req_id, sew, meta_vm, meta_cnt} = meta_q[0];
        meta_sew = vlsu_req_pkg::sew_e'(sew);
        if (meta_ready) begin
          void'(meta_q.pop_front());
        end
      end
      r         = rand_bits(1);
      msk_valid = (msk_q.size() != 0) && (!gaps || r[0]);
      if (msk_valid) begin
        {sew, msk_elem} = msk_q[0];
        msk_sew = vlsu_req_pkg::sew_e'(sew);
        if (msk_ready) begin
          void'(msk_q.pop_front());
        end
      end
      // Each lane walks the beat list on its own
      for (int l = 0; l < NR_EXITS; l++) begin
        r             = rand_bits(2);
        lane_valid[l] = (lane_ptr[l] < beat_q.size()) && (!gaps || (r[1:0] != 2'b00));
        if (lane_valid[l]) begin
          chunks                   = beat_q[lane_ptr[l]];
          lane_data[l*DLEN +: DLEN] = chunks[l*DLEN +: DLEN];
          if (lane_ready[l]) begin
            lane_ptr[l]++;
          end
        end
      end
    end
    lane_valid = '0;
    meta_valid = 1'b0;
    msk_valid  = 1'b0;
    mem_ready  = 1'b1;
  endtask

  // Fills the metadata queue without lane data
  task automatic fill_meta_queue();
    int unsigned acc;
    int unsigned cyc;
    logic [1:0]  sew;
    for (int s = 0; s < SHF_INFO_DEPTH; s++) begin
      add_request(s % 4, 1);
    end
    acc = 0;
    cyc = 0;
    while (meta_q.size() != 0 && cyc < 50) begin
      @(negedge clk);
      cyc++;
      meta_valid = 1'b1;
      {meta_req_id, sew, meta_vm, meta_cnt} = meta_q[0];
      meta_sew = vlsu_req_pkg::sew_e'(sew);
      if (meta_ready) begin
        void'(meta_q.pop_front());
        acc++;
      end
    end
    if (meta_q.size() != 0) begin
      $display("Timeout: metadata queue took only %0d requests", acc);
      tmo_cnt++;
    end
    @(negedge clk);
    meta_valid = 1'b0;
    assert (!meta_ready) else begin
      $display("FAILED %0t: meta_ready_o high after %0d requests", $time, acc);
      err_cnt++;
    end
  endtask

  // --------------------------------------------------
  // Test sequence
  // --------------------------------------------------
  initial begin
    int unsigned cyc;
    lfsr_state     = 32'hb313_ed6c;
    next_id        = '0;
    want_meta_free = 1'b0;
    chk_cnt        = 0;
    err_cnt        = 0;
    tmo_cnt        = 0;
    for (int l = 0; l < NR_EXITS; l++) begin
      lane_ptr[l] = 0;
    end
    lane_valid  = '0;
    lane_data   = '0;
    meta_valid  = 1'b0;
    meta_req_id = '0;
    meta_sew    = vlsu_req_pkg::SEW8;
    meta_vm     = 1'b0;
    meta_cnt    = '0;
    msk_valid   = 1'b0;
    msk_sew     = vlsu_req_pkg::SEW8;
    msk_elem    = '0;
    mem_ready   = 1'b1;

    cyc = 0;
    while (!rst_n && cyc < 100) begin
      @(negedge clk);
      cyc++;
    end
    if (!rst_n) begin
      $display("Timeout: reset was never released");
      tmo_cnt++;
    end
    @(negedge clk);
    assert (!mem_valid && (lane_ready == '1) && meta_ready && msk_ready) else begin
      $display("FAILED %0t: after reset mem_valid %b lane_ready %b meta_ready %b msk_ready %b",
               $time, mem_valid, lane_ready, meta_ready, msk_ready);
      err_cnt++;
    end

    // Fill the queue and drain one unmasked request per width
    fill_meta_queue();
    want_meta_free = 1'b1;
    run_traffic(1'b1, 2000);

    // Mixed masked traffic with random gaps everywhere
    for (int i = 0; i < 48; i++) begin
      add_request(-1, -1);
    end
    run_traffic(1'b1, 20000);

    // Nothing may follow the last checked beat
    repeat (8) begin
      @(negedge clk);
      assert (!mem_valid) else begin
        $display("Extra memory write at %0t after all beats were checked", $time);
        err_cnt++;
      end
    end

    $display("Beats checked: %0d, errors: %0d, timeouts: %0d", chk_cnt, err_cnt, tmo_cnt);
    if (err_cnt == 0 && tmo_cnt == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
src/vlsu_geom_pkg.sv
src/vlsu_req_pkg.sv
src/mask_unit.sv
src/mdeshuffle_unit.sv
src/seq_store_unit.sv
src/vlsu_store_top.sv
sim/tb_clk_gen.sv
sim/tb_vlsu_store.sv

//--- Makefile
# Verilator build and run for the store deshuffle testbench

TOP := tb_vlsu_store

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -j 0 --timescale 1ns/1ps \
		--top-module $(TOP) -f filelist.f --Mdir obj_dir -o $(TOP)

# The log decides pass or fail, not the simulator exit code
run: compile
	./obj_dir/$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "All tests passed!" sim.log

clean:
	rm -rf obj_dir sim.log
